/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_rv_core -f rv_core.f -o sim_rv_core

# The log decides the verdict, so a failing run must not abort the script here
./obj_dir/sim_rv_core > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    echo "RESULT: FAIL"
    exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
    echo "RESULT: FAIL (run ended early)"
    exit 1
fi
echo "RESULT: PASS"

/* rv_core.f */
rv_core_pkg.sv
rv_core_regfile.sv
rv_core_ifu.sv
rv_core_idu.sv
rv_core_exu.sv
rv_core_mem.sv
rv_core_wbu.sv
rv_core.sv
rv_core_assert.sv
tb_rv_core.sv

/* rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
    parameter int DMEM_WORDS = 256
) (
    input  wire                     clk,
    input  wire                     arst_n_i,
    output rv_core_pkg::word_t      imem_addr_o,
    input  wire rv_core_pkg::inst_t imem_rdata_i,
    output logic                    retire_o,
    output rv_core_pkg::word_t      retire_pc_o,
    output rv_core_pkg::reg_addr_t  retire_rd_o,
    output logic                    retire_we_o,
    output rv_core_pkg::word_t      retire_wdata_o
);
    import rv_core_pkg::*;

    // Stage strobes
    logic inst_valid, id_done, exu_done, mem_done, pc_wen;

    // Fetch and register file
    word_t     if_pc, next_pc;
    inst_t     if_inst;
    reg_addr_t rs1_addr, rs2_addr, waddr;
    word_t     rs1_data, rs2_data, wdata;
    logic      rf_we;

    // Decode to execute
    word_t     id_op1, id_op2, id_rs2_data, id_pc;
    alu_op_e   id_alu_op;
    reg_addr_t id_rd;
    wb_sel_e   id_wb_sel;
    logic      id_mem_wen;

    // Execute to memory
    word_t     ex_result, ex_rs2_data, ex_pc;
    reg_addr_t ex_rd;
    wb_sel_e   ex_wb_sel;
    logic      ex_mem_wen;

    // Memory to write-back
    word_t     mem_result, mem_load_data, mem_pc;
    reg_addr_t mem_rd;
    wb_sel_e   mem_wb_sel;

    rv_core_regfile u_regfile (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (rf_we),
        .waddr_i    (waddr),
        .wdata_i    (wdata)
    );

    rv_core_ifu u_ifu (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .pc_wen_i     (pc_wen),
        .next_pc_i    (next_pc),
        .imem_addr_o  (imem_addr_o),
        .imem_rdata_i (imem_rdata_i),
        .pc_o         (if_pc),
        .inst_o       (if_inst),
        .inst_valid_o (inst_valid)
    );

    rv_core_idu u_idu (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .inst_i       (if_inst),
        .pc_i         (if_pc),
        .inst_valid_i (inst_valid),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .op1_o        (id_op1),
        .op2_o        (id_op2),
        .alu_op_o     (id_alu_op),
        .rs2_data_o   (id_rs2_data),
        .rd_addr_o    (id_rd),
        .wb_sel_o     (id_wb_sel),
        .mem_wen_o    (id_mem_wen),
        .pc_o         (id_pc),
        .next_pc_o    (next_pc),
        .id_done_o    (id_done)
    );

    rv_core_exu u_exu (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .op1_i      (id_op1),
        .op2_i      (id_op2),
        .alu_op_i   (id_alu_op),
        .rs2_data_i (id_rs2_data),
        .rd_addr_i  (id_rd),
        .wb_sel_i   (id_wb_sel),
        .mem_wen_i  (id_mem_wen),
        .pc_i       (id_pc),
        .id_done_i  (id_done),
        .result_o   (ex_result),
        .rs2_data_o (ex_rs2_data),
        .rd_addr_o  (ex_rd),
        .wb_sel_o   (ex_wb_sel),
        .mem_wen_o  (ex_mem_wen),
        .pc_o       (ex_pc),
        .exu_done_o (exu_done)
    );

    rv_core_mem #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_mem (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .result_i    (ex_result),
        .rs2_data_i  (ex_rs2_data),
        .rd_addr_i   (ex_rd),
        .wb_sel_i    (ex_wb_sel),
        .mem_wen_i   (ex_mem_wen),
        .pc_i        (ex_pc),
        .exu_done_i  (exu_done),
        .result_o    (mem_result),
        .load_data_o (mem_load_data),
        .rd_addr_o   (mem_rd),
        .wb_sel_o    (mem_wb_sel),
        .pc_o        (mem_pc),
        .mem_done_o  (mem_done)
    );

    rv_core_wbu u_wbu (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .result_i       (mem_result),
        .load_data_i    (mem_load_data),
        .rd_addr_i      (mem_rd),
        .wb_sel_i       (mem_wb_sel),
        .pc_i           (mem_pc),
        .mem_done_i     (mem_done),
        .rf_we_o        (rf_we),
        .waddr_o        (waddr),
        .wdata_o        (wdata),
        .pc_wen_o       (pc_wen),
        .retire_o       (retire_o),
        .retire_pc_o    (retire_pc_o),
        .retire_rd_o    (retire_rd_o),
        .retire_we_o    (retire_we_o),
        .retire_wdata_o (retire_wdata_o)
    );

endmodule

`default_nettype wire

/* rv_core_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_assert (
    input wire clk,
    input wire arst_n_i,
    input wire inst_valid_i,
    input wire id_done_i,
    input wire exu_done_i,
    input wire mem_done_i,
    input wire pc_wen_i,
    input wire retire_i
);

    // Every strobe lasts exactly one cycle
    inst_valid_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        inst_valid_i |=> !inst_valid_i)
        else $error("inst_valid high for more than one cycle");
    id_done_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        id_done_i |=> !id_done_i)
        else $error("id_done high for more than one cycle");
    exu_done_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        exu_done_i |=> !exu_done_i)
        else $error("exu_done high for more than one cycle");
    mem_done_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        mem_done_i |=> !mem_done_i)
        else $error("mem_done high for more than one cycle");
    pc_wen_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        pc_wen_i |=> !pc_wen_i)
        else $error("pc_wen high for more than one cycle");

    // Decode answers one cycle after fetch
    id_after_fetch: assert property (@(posedge clk) disable iff (!arst_n_i)
        inst_valid_i |=> id_done_i)
        else $error("id_done missing one cycle after inst_valid");
    id_has_cause: assert property (@(posedge clk) disable iff (!arst_n_i)
        id_done_i |-> $past(inst_valid_i))
        else $error("id_done without inst_valid in the previous cycle");

    retire_with_pc_wen: assert property (@(posedge clk) disable iff (!arst_n_i)
        retire_i == pc_wen_i)
        else $error("retire and pc_wen out of step");

    // Only one instruction in flight
    one_strobe: assert property (@(posedge clk) disable iff (!arst_n_i)
        $onehot0({inst_valid_i, id_done_i, exu_done_i, mem_done_i, pc_wen_i}))
        else $error("more than one stage strobe high");

endmodule

bind rv_core rv_core_assert u_assert (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .inst_valid_i (inst_valid),
    .id_done_i    (id_done),
    .exu_done_i   (exu_done),
    .mem_done_i   (mem_done),
    .pc_wen_i     (pc_wen),
    .retire_i     (retire_o)
);

`default_nettype wire

/* rv_core_exu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_exu (
    input  wire                         clk,
    input  wire                         arst_n_i,
    input  wire rv_core_pkg::word_t     op1_i,
    input  wire rv_core_pkg::word_t     op2_i,
    input  wire rv_core_pkg::alu_op_e   alu_op_i,
    input  wire rv_core_pkg::word_t     rs2_data_i,
    input  wire rv_core_pkg::reg_addr_t rd_addr_i,
    input  wire rv_core_pkg::wb_sel_e   wb_sel_i,
    input  wire                         mem_wen_i,
    input  wire rv_core_pkg::word_t     pc_i,
    input  wire                         id_done_i,
    output rv_core_pkg::word_t          result_o,
    output rv_core_pkg::word_t          rs2_data_o,
    output rv_core_pkg::reg_addr_t      rd_addr_o,
    output rv_core_pkg::wb_sel_e        wb_sel_o,
    output logic                        mem_wen_o,
    output rv_core_pkg::word_t          pc_o,
    output logic                        exu_done_o
);
    import rv_core_pkg::*;

    word_t alu_res;
    logic  lt_signed;

    assign lt_signed = $signed(op1_i) < $signed(op2_i);

    // Loads and stores use ALU_ADD to form base plus offset
    always_comb begin
        case (alu_op_i)
            ALU_ADD:   alu_res = op1_i + op2_i;
            ALU_SUB:   alu_res = op1_i - op2_i;
            ALU_AND:   alu_res = op1_i & op2_i;
            ALU_OR:    alu_res = op1_i | op2_i;
            ALU_XOR:   alu_res = op1_i ^ op2_i;
            ALU_SLT:   alu_res = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_PASSB: alu_res = op2_i;
            default:   alu_res = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exu_done_o <= 1'b0;
            mem_wen_o  <= 1'b0;
            wb_sel_o   <= WB_NONE;
        end else begin
            exu_done_o <= id_done_i;
            if (id_done_i) begin
                mem_wen_o <= mem_wen_i;
                wb_sel_o  <= wb_sel_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (id_done_i) begin
            result_o   <= alu_res;
            rs2_data_o <= rs2_data_i;
            rd_addr_o  <= rd_addr_i;
            pc_o       <= pc_i;
        end
    end

endmodule

`default_nettype wire

/* rv_core_idu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_idu (
    input  wire                     clk,
    input  wire                     arst_n_i,
    input  wire rv_core_pkg::inst_t inst_i,
    input  wire rv_core_pkg::word_t pc_i,
    input  wire                     inst_valid_i,
    output rv_core_pkg::reg_addr_t  rs1_addr_o,
    output rv_core_pkg::reg_addr_t  rs2_addr_o,
    input  wire rv_core_pkg::word_t rs1_data_i,
    input  wire rv_core_pkg::word_t rs2_data_i,
    output rv_core_pkg::word_t      op1_o,
    output rv_core_pkg::word_t      op2_o,
    output rv_core_pkg::alu_op_e    alu_op_o,
    output rv_core_pkg::word_t      rs2_data_o,
    output rv_core_pkg::reg_addr_t  rd_addr_o,
    output rv_core_pkg::wb_sel_e    wb_sel_o,
    output logic                    mem_wen_o,
    output rv_core_pkg::word_t      pc_o,
    output rv_core_pkg::word_t      next_pc_o,
    output logic                    id_done_o
);
    import rv_core_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
    word_t      op2_d, next_pc_d;
    alu_op_e    alu_op_d;
    wb_sel_e    wb_sel_d;
    logic       mem_wen_d;
    logic       br_taken;

    assign opcode     = inst_i[6:0];
    assign funct3     = inst_i[14:12];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    // BEQ on funct3 000, BNE on 001
    assign br_taken = (funct3 == 3'b000) ? (rs1_data_i == rs2_data_i) :
                      (funct3 == 3'b001) ? (rs1_data_i != rs2_data_i) : 1'b0;

    always_comb begin
        op2_d     = imm_i;
        alu_op_d  = ALU_ADD;
        wb_sel_d  = WB_NONE;
        mem_wen_d = 1'b0;
        next_pc_d = pc_i + 32'd4;
        case (opcode)
            OP_IMM, OP_REG: begin
                wb_sel_d = WB_ALU;
                if (opcode == OP_REG) begin
                    op2_d = rs2_data_i;
                end
                case (funct3)
                    3'b000: begin
                        alu_op_d = (opcode == OP_REG && inst_i[30]) ? ALU_SUB : ALU_ADD;
                    end
                    3'b010:  alu_op_d = ALU_SLT;
                    3'b100:  alu_op_d = ALU_XOR;
                    3'b110:  alu_op_d = ALU_OR;
                    3'b111:  alu_op_d = ALU_AND;
                    default: alu_op_d = ALU_ADD;
                endcase
            end
            OP_LUI: begin
                op2_d    = imm_u;
                alu_op_d = ALU_PASSB;
                wb_sel_d = WB_ALU;
            end
            OP_LOAD: wb_sel_d = WB_MEM;
            OP_STORE: begin
                op2_d     = imm_s;
                mem_wen_d = 1'b1;
            end
            OP_BRANCH: begin
                if (br_taken) begin
                    next_pc_d = pc_i + imm_b;
                end
            end
            OP_JAL: begin
                wb_sel_d  = WB_PC4;
                next_pc_d = pc_i + imm_j;
            end
            // Unknown opcodes fall through as a no-op
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_done_o <= 1'b0;
            mem_wen_o <= 1'b0;
            wb_sel_o  <= WB_NONE;
            next_pc_o <= RESET_PC;
        end else begin
            id_done_o <= inst_valid_i;
            if (inst_valid_i) begin
                mem_wen_o <= mem_wen_d;
                wb_sel_o  <= wb_sel_d;
                next_pc_o <= next_pc_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid_i) begin
            op1_o      <= rs1_data_i;
            op2_o      <= op2_d;
            alu_op_o   <= alu_op_d;
            rs2_data_o <= rs2_data_i;
            rd_addr_o  <= inst_i[11:7];
            pc_o       <= pc_i;
        end
    end

endmodule

`default_nettype wire

/* rv_core_ifu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_ifu (
    input  wire                     clk,
    input  wire                     arst_n_i,
    input  wire                     pc_wen_i,
    input  wire rv_core_pkg::word_t next_pc_i,
    output rv_core_pkg::word_t      imem_addr_o,
    input  wire rv_core_pkg::inst_t imem_rdata_i,
    output rv_core_pkg::word_t      pc_o,
    output rv_core_pkg::inst_t      inst_o,
    output logic                    inst_valid_o
);
    import rv_core_pkg::*;

    typedef enum logic [1:0] {
        FETCH,
        WAIT,
        HOLD
    } state_e;

    state_e state_q;
    word_t  pc_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q      <= FETCH;
            pc_q         <= RESET_PC;
            inst_valid_o <= 1'b0;
        end else begin
            inst_valid_o <= 1'b0;
            case (state_q)
                FETCH: begin
                    inst_valid_o <= 1'b1;
                    state_q      <= WAIT;
                end
                WAIT: state_q <= HOLD;
                // Stay here until write-back releases the next PC
                HOLD: begin
                    if (pc_wen_i) begin
                        pc_q    <= next_pc_i;
                        state_q <= FETCH;
                    end
                end
                default: state_q <= FETCH;
            endcase
        end
    end

    // Instruction memory answers in the same cycle
    always_ff @(posedge clk) begin
        if (state_q == FETCH) begin
            inst_o <= imem_rdata_i;
        end
    end

    assign imem_addr_o = pc_q;
    assign pc_o        = pc_q;

endmodule

`default_nettype wire

/* rv_core_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_mem #(
    parameter int DMEM_WORDS = 256
) (
    input  wire                         clk,
    input  wire                         arst_n_i,
    input  wire rv_core_pkg::word_t     result_i,
    input  wire rv_core_pkg::word_t     rs2_data_i,
    input  wire rv_core_pkg::reg_addr_t rd_addr_i,
    input  wire rv_core_pkg::wb_sel_e   wb_sel_i,
    input  wire                         mem_wen_i,
    input  wire rv_core_pkg::word_t     pc_i,
    input  wire                         exu_done_i,
    output rv_core_pkg::word_t          result_o,
    output rv_core_pkg::word_t          load_data_o,
    output rv_core_pkg::reg_addr_t      rd_addr_o,
    output rv_core_pkg::wb_sel_e        wb_sel_o,
    output rv_core_pkg::word_t          pc_o,
    output logic                        mem_done_o
);
    import rv_core_pkg::*;

    localparam int IDX_W = $clog2(DMEM_WORDS);

    word_t            ram [DMEM_WORDS];
    logic [IDX_W-1:0] idx;

    // Word index, upper address bits are dropped so accesses wrap
    assign idx = result_i[IDX_W+1:2];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                ram[i] <= '0;
            end
        end else if (exu_done_i && mem_wen_i) begin
            ram[idx] <= rs2_data_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_done_o <= 1'b0;
            wb_sel_o   <= WB_NONE;
        end else begin
            mem_done_o <= exu_done_i;
            if (exu_done_i) begin
                wb_sel_o <= wb_sel_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (exu_done_i) begin
            if (!mem_wen_i) begin
                load_data_o <= ram[idx];
            end
            result_o  <= result_i;
            rd_addr_o <= rd_addr_i;
            pc_o      <= pc_i;
        end
    end

endmodule

`default_nettype wire

/* rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

    // Datapath width, fixed at 32 for RV32I
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [6:0]      opcode_t;

    // Major opcodes of the supported subset
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASSB
    } alu_op_e;

    // Source of the register write-back value
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4,
        WB_NONE
    } wb_sel_e;

    localparam word_t RESET_PC = '0;

endpackage

`default_nettype wire

/* rv_core_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_regfile (
    input  wire                       clk,
    input  wire                       arst_n_i,
    input  wire rv_core_pkg::reg_addr_t rs1_addr_i,
    input  wire rv_core_pkg::reg_addr_t rs2_addr_i,
    output rv_core_pkg::word_t        rs1_data_o,
    output rv_core_pkg::word_t        rs2_data_o,
    input  wire                       we_i,
    input  wire rv_core_pkg::reg_addr_t waddr_i,
    input  wire rv_core_pkg::word_t   wdata_i
);
    import rv_core_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 is hardwired to zero
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

`default_nettype wire

/* rv_core_wbu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_wbu (
    input  wire                         clk,
    input  wire                         arst_n_i,
    input  wire rv_core_pkg::word_t     result_i,
    input  wire rv_core_pkg::word_t     load_data_i,
    input  wire rv_core_pkg::reg_addr_t rd_addr_i,
    input  wire rv_core_pkg::wb_sel_e   wb_sel_i,
    input  wire rv_core_pkg::word_t     pc_i,
    input  wire                         mem_done_i,
    output logic                        rf_we_o,
    output rv_core_pkg::reg_addr_t      waddr_o,
    output rv_core_pkg::word_t          wdata_o,
    output logic                        pc_wen_o,
    output logic                        retire_o,
    output rv_core_pkg::word_t          retire_pc_o,
    output rv_core_pkg::reg_addr_t      retire_rd_o,
    output logic                        retire_we_o,
    output rv_core_pkg::word_t          retire_wdata_o
);
    import rv_core_pkg::*;

    word_t wb_data;
    logic  wb_en;

    assign wb_en = (wb_sel_i != WB_NONE);

    always_comb begin
        case (wb_sel_i)
            WB_MEM:  wb_data = load_data_i;
            WB_PC4:  wb_data = pc_i + 32'd4;
            default: wb_data = result_i;
        endcase
    end

    // Write, PC update and retire all fire in the same cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rf_we_o  <= 1'b0;
            pc_wen_o <= 1'b0;
            retire_o <= 1'b0;
        end else begin
            rf_we_o  <= mem_done_i && wb_en;
            pc_wen_o <= mem_done_i;
            retire_o <= mem_done_i;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_done_i) begin
            waddr_o     <= rd_addr_i;
            wdata_o     <= wb_data;
            retire_pc_o <= pc_i;
            retire_we_o <= wb_en;
        end
    end

    assign retire_rd_o    = waddr_o;
    assign retire_wdata_o = wdata_o;

endmodule

`default_nettype wire

/* tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
    import rv_core_pkg::*;

    localparam int          IMEM_WORDS     = 256;
    localparam int          IMEM_AW        = $clog2(IMEM_WORDS);
    localparam int          DMEM_WORDS     = 256;
    localparam int          DMEM_AW        = $clog2(DMEM_WORDS);
    localparam int          RESET_CYCLES   = 10;
    localparam int unsigned NUM_RETIRES    = 400;
    localparam int unsigned TIMEOUT_CYCLES = NUM_RETIRES * 6 + 200;
    localparam int unsigned SEED           = 32'heaa9_e448;

    logic      clk;
    logic      arst_n;
    word_t     imem_addr;
    inst_t     imem_rdata;
    logic      retire;
    word_t     retire_pc;
    reg_addr_t retire_rd;
    logic      retire_we;
    word_t     retire_wdata;

    inst_t imem [IMEM_WORDS];

    // ISA model state
    word_t model_regs [32];
    word_t model_dmem [DMEM_WORDS];
    word_t model_pc;

    int unsigned retire_count = 0;
    int unsigned cycle_count  = 0;

    rv_core #(
        .DMEM_WORDS (DMEM_WORDS)
    ) uut (
        .clk            (clk),
        .arst_n_i       (arst_n),
        .imem_addr_o    (imem_addr),
        .imem_rdata_i   (imem_rdata),
        .retire_o       (retire),
        .retire_pc_o    (retire_pc),
        .retire_rd_o    (retire_rd),
        .retire_we_o    (retire_we),
        .retire_wdata_o (retire_wdata)
    );

    // Instruction memory answers in the same cycle
    assign imem_rdata = imem[imem_addr[IMEM_AW+1:2]];

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    function automatic inst_t i_type(input word_t imm, input reg_addr_t rs1,
                                     input logic [2:0] f3, input reg_addr_t rd,
                                     input opcode_t op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic inst_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3,
                                     input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic inst_t s_type(input word_t imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic inst_t b_type(input word_t imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic inst_t j_type(input word_t imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    // Registers x0..x7 only, so results feed each other often
    function automatic reg_addr_t rand_reg();
        word_t r;
        r = $urandom;
        return {2'b00, r[2:0]};
    endfunction

    function automatic word_t rand_imm12();
        word_t r;
        r = $urandom;
        return {{20{r[11]}}, r[11:0]};
    endfunction

    // Sixteen word slots, half of them reached through a negative wrapping offset
    function automatic word_t mem_offset();
        word_t r;
        word_t off;
        r   = $urandom;
        off = {26'd0, r[3:0], 2'b00};
        if (r[4]) begin
            off = off - word_t'(DMEM_WORDS * 4);
        end
        return off;
    endfunction

    // Forward target, never past the last word
    function automatic word_t jump_offset(input int idx);
        word_t r;
        int    span;
        r    = $urandom;
        span = 1 + int'(r[2:0]);
        if (idx + span > IMEM_WORDS - 1) begin
            span = IMEM_WORDS - 1 - idx;
        end
        return word_t'(span * 4);
    endfunction

    function automatic void build_program();
        word_t     r;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        for (int i = 0; i < IMEM_WORDS - 1; i++) begin
            r   = $urandom;
            rd  = rand_reg();
            rs1 = rand_reg();
            rs2 = rand_reg();
            case (r[3:0])
                4'd0:    imem[i] = i_type(rand_imm12(), rs1, 3'b000, rd, OP_IMM);
                4'd1:    imem[i] = i_type(rand_imm12(), rs1, 3'b111, rd, OP_IMM);
                4'd2:    imem[i] = i_type(rand_imm12(), rs1, 3'b110, rd, OP_IMM);
                4'd3:    imem[i] = i_type(rand_imm12(), rs1, 3'b100, rd, OP_IMM);
                4'd4:    imem[i] = r_type(7'b0000000, rs2, rs1, 3'b000, rd);
                4'd5:    imem[i] = r_type(7'b0100000, rs2, rs1, 3'b000, rd);
                4'd6:    imem[i] = r_type(7'b0000000, rs2, rs1, 3'b111, rd);
                4'd7:    imem[i] = r_type(7'b0000000, rs2, rs1, 3'b110, rd);
                4'd8:    imem[i] = r_type(7'b0000000, rs2, rs1, 3'b100, rd);
                4'd9:    imem[i] = r_type(7'b0000000, rs2, rs1, 3'b010, rd);
                4'd10:   imem[i] = {r[31:12], rd, OP_LUI};
                4'd11:   imem[i] = i_type(mem_offset(), 5'd0, 3'b010, rd, OP_LOAD);
                4'd12:   imem[i] = s_type(mem_offset(), rs2, 5'd0);
                4'd13:   imem[i] = b_type(jump_offset(i), rs2, rs1, 3'b000);
                4'd14:   imem[i] = b_type(jump_offset(i), rs2, rs1, 3'b001);
                default: imem[i] = j_type(jump_offset(i), rd);
            endcase
        end
        // Close the loop back to address 0
        imem[IMEM_WORDS-1] = j_type(word_t'(-(IMEM_WORDS - 1) * 4), 5'd0);
    endfunction

    // One instruction of the ISA model, returns what the core should retire
    function automatic void model_step(output word_t pc, output reg_addr_t rd,
                                       output logic we, output word_t wdata);
        inst_t      inst;
        logic [2:0] f3;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        word_t      imm_j;
        word_t      addr;
        word_t      next_pc;
        inst    = imem[model_pc[IMEM_AW+1:2]];
        f3      = inst[14:12];
        rd      = inst[11:7];
        a       = model_regs[inst[19:15]];
        b       = model_regs[inst[24:20]];
        imm_i   = {{20{inst[31]}}, inst[31:20]};
        imm_s   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        imm_b   = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j   = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        pc      = model_pc;
        we      = 1'b0;
        wdata   = '0;
        next_pc = model_pc + 32'd4;
        case (inst[6:0])
            OP_IMM, OP_REG: begin
                we = 1'b1;
                if (inst[6:0] == OP_IMM) begin
                    b = imm_i;
                end
                case (f3)
                    3'b000: wdata = (inst[6:0] == OP_REG && inst[30]) ? a - b : a + b;
                    3'b010: wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b100: wdata = a ^ b;
                    3'b110: wdata = a | b;
                    default: wdata = a & b;
                endcase
            end
            OP_LUI: begin
                we    = 1'b1;
                wdata = {inst[31:12], 12'd0};
            end
            OP_LOAD: begin
                we    = 1'b1;
                addr  = a + imm_i;
                wdata = model_dmem[addr[DMEM_AW+1:2]];
            end
            OP_STORE: begin
                addr = a + imm_s;
                model_dmem[addr[DMEM_AW+1:2]] = b;
            end
            OP_BRANCH: begin
                if ((f3 == 3'b000) ? (a == b) : (a != b)) begin
                    next_pc = model_pc + imm_b;
                end
            end
            OP_JAL: begin
                we      = 1'b1;
                wdata   = model_pc + 32'd4;
                next_pc = model_pc + imm_j;
            end
            default: ;
        endcase
        if (we && rd != 5'd0) begin
            model_regs[rd] = wdata;
        end
        model_pc = next_pc;
    endfunction

    // Compare every retire against the model
    always @(negedge clk) begin : check_retire
        word_t     exp_pc;
        reg_addr_t exp_rd;
        logic      exp_we;
        word_t     exp_wdata;
        if (arst_n && retire) begin
            model_step(exp_pc, exp_rd, exp_we, exp_wdata);
            assert (retire_pc == exp_pc) else
                fail_now($sformatf("Mismatch retire_pc_o: got %h expected %h",
                                   retire_pc, exp_pc));
            assert (retire_we == exp_we) else
                fail_now($sformatf("Mismatch retire_we_o: got %h expected %h at pc %h",
                                   retire_we, exp_we, exp_pc));
            if (exp_we) begin
                assert (retire_rd == exp_rd) else
                    fail_now($sformatf("Mismatch retire_rd_o: got %h expected %h at pc %h",
                                       retire_rd, exp_rd, exp_pc));
                assert (retire_wdata == exp_wdata) else
                    fail_now($sformatf("Mismatch retire_wdata_o: got %h expected %h at pc %h",
                                       retire_wdata, exp_wdata, exp_pc));
            end
            retire_count = retire_count + 1;
        end
    end

    always @(negedge clk) begin
        if (arst_n) begin
            cycle_count <= cycle_count + 1;
        end
    end

    initial begin
        int unsigned seed_ret;
        arst_n   = 1'b0;
        seed_ret = $urandom(SEED);
        build_program();
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            model_dmem[i] = '0;
        end
        model_pc = RESET_PC;
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        while (retire_count < NUM_RETIRES && cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        if (retire_count >= NUM_RETIRES) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            fail_now($sformatf("Timeout: no retire arrived in time, %0d of %0d after %0d cycles",
                               retire_count, NUM_RETIRES, cycle_count));
        end
    end

endmodule

`default_nettype wire
